// ==== Makefile ====
# Verilator build and run for the alignment buffer testbench

TOP := tb_alignment_buffer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

# Pass or fail is read from the log
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/albuf_config.svh ====
// Build constants for the instruction alignment buffer
// Include this in any module that sizes its storage or counters
// from the buffer depth, or that decodes instruction length

`ifndef ALBUF_CONFIG_SVH
`define ALBUF_CONFIG_SVH

// Number of 32-bit words the buffer can hold
`define ALBUF_DEPTH 3

// Pointer and counter width, enough to index ALBUF_DEPTH entries
`define ALBUF_CNT_W 2

// Fetch requests allowed in flight at once
`define ALBUF_MAX_OUTSTANDING 2

// Low two bits of a halfword that start a 32-bit instruction
// Any other code marks a compressed 16-bit instruction
`define ALBUF_UNCOMP 2'b11

// Word width on the instruction bus
`define ALBUF_WORD_W 32

`endif

// ==== design/albuf_pkg.sv ====
// Shared types for the instruction alignment buffer
// Ports use scoped names, module bodies import what they need

`default_nettype none

package albuf_pkg;

  //////////////////////////////////////////////////
  // Bundles that cross module boundaries
  //////////////////////////////////////////////////

  // Control from the core
  // branch is a single-cycle pulse, branch_addr is the new halfword target
  typedef struct packed {
    logic        instr_req;
    logic        branch;
    logic [31:0] branch_addr;
  } albuf_ctrl_t;

  // One word response from instruction memory
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } inst_resp_t;

  // Instruction handed to the decode stage
  // Compressed instructions sit in the low halfword, upper half zero
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
    logic        err;
  } instr_out_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Where the write side stands in the halfword stream
  // UNALIGNED_AFTER_BRANCH drops the low half of the next word
  // UNALIGNED_SPLIT means the low half ends a 32-bit instruction
  typedef enum logic [1:0] {
    ALIGNED,
    UNALIGNED_AFTER_BRANCH,
    UNALIGNED_SPLIT
  } align_state_e;

  // Length decoded from the low bits of a halfword
  typedef enum logic {
    LEN_16,
    LEN_32
  } instr_len_e;

endpackage

`default_nettype wire

// ==== design/alignment_buffer.sv ====
// Top level of the instruction alignment buffer
// Sits between the prefetcher and the decode stage: requests words,
// keeps them in a small store and emits whole RISC-V instructions,
// compressed or not, with address and bus error

`timescale 1ns/1ps
`default_nettype none

module alignment_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  albuf_pkg::albuf_ctrl_t ctrl_i,
  output logic                   fetch_valid_o,
  input  logic                   fetch_ready_i,
  output logic                   fetch_branch_o,
  output logic [31:0]            fetch_branch_addr_o,
  input  logic                   resp_valid_i,
  input  albuf_pkg::inst_resp_t  resp_i,
  output logic                   instr_valid_o,
  input  logic                   instr_ready_i,
  output albuf_pkg::instr_out_t  instr_o,
  output logic                   busy_o,
  output logic                   protocol_err_o
);
  import albuf_pkg::*;

  inst_resp_t head, next_resp;
  logic       head_valid, next_valid;
  logic       resp_accept;
  logic       instr_fire;
  logic       word_pop;

  // Prefetcher retargets on the branch pulse, halfword aligned
  assign fetch_branch_o      = ctrl_i.branch;
  assign fetch_branch_addr_o = {ctrl_i.branch_addr[31:1], 1'b0};

  //////////////////////////////////////////////////
  // Request side and word store
  //////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_i         (ctrl_i),
    .fetch_ready_i  (fetch_ready_i),
    .resp_valid_i   (resp_valid_i),
    .resp_i         (resp_i),
    .instr_fire_i   (instr_fire),
    .fetch_valid_o  (fetch_valid_o),
    .resp_accept_o  (resp_accept),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o)
  );

  // Branch flushes every stored word
  word_fifo u_word_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.branch),
    .push_i       (resp_accept),
    .resp_i       (resp_i),
    .pop_i        (word_pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .next_o       (next_resp),
    .next_valid_o (next_valid)
  );

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .head_i        (head),
    .head_valid_i  (head_valid),
    .next_i        (next_resp),
    .next_valid_i  (next_valid),
    .resp_accept_i (resp_accept),
    .resp_i        (resp_i),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_fire_o  (instr_fire),
    .word_pop_o    (word_pop)
  );

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
// Fetch request control for the alignment buffer
// Decides when a new word may be requested, tracks requests in flight,
// drops stale responses after a branch and flags stray responses
// Instruction counting runs on the write side over incoming halfwords

`timescale 1ns/1ps
`default_nettype none

`include "albuf_config.svh"

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  albuf_pkg::albuf_ctrl_t ctrl_i,
  input  logic                   fetch_ready_i,
  input  logic                   resp_valid_i,
  input  albuf_pkg::inst_resp_t  resp_i,
  input  logic                   instr_fire_i,
  output logic                   fetch_valid_o,
  output logic                   resp_accept_o,
  output logic                   busy_o,
  output logic                   protocol_err_o
);
  import albuf_pkg::*;

  localparam int CNT_W   = `ALBUF_CNT_W;
  localparam int MAX_OUT = `ALBUF_MAX_OUTSTANDING;

  // Requests in flight and stale responses still to drop
  logic [CNT_W-1:0] outstanding_q, outstanding_n;
  logic [CNT_W-1:0] flush_q, flush_n;
  // Count of complete instructions held
  // One bit wider than the word pointer
  logic [CNT_W:0]   instr_cnt_q, instr_cnt_n, instr_cnt_adj;
  logic [1:0]       n_incoming;
  logic             pop_q;
  logic             req_fire;
  logic             resp_seen;
  align_state_e     state_q, state_n;
  instr_len_e       lo_len, hi_len;

  assign req_fire  = fetch_valid_o && fetch_ready_i;
  // A stray response must not wrap the counter below zero
  assign resp_seen = resp_valid_i && (outstanding_q != '0);

  // Responses pass only when nothing stale is pending
  // The response in a branch cycle belongs to the old stream
  assign resp_accept_o = resp_valid_i && (flush_q == '0) && !ctrl_i.branch;

  // Emitted instructions come off the count one cycle late
  assign instr_cnt_adj = instr_cnt_q - {{CNT_W{1'b0}}, pop_q};

  //////////////////////////////////////////////////
  // Request decision
  //////////////////////////////////////////////////

  // Room for another word when the buffer is drained or holds one
  // instruction with nothing in flight
  // A branch always restarts fetch
  assign fetch_valid_o = ctrl_i.instr_req &&
                         (outstanding_q < CNT_W'(MAX_OUT)) &&
                         ((instr_cnt_adj == '0) ||
                          ((instr_cnt_adj == (CNT_W+1)'(1)) && (outstanding_q == '0)) ||
                          ctrl_i.branch);

  assign busy_o         = (outstanding_q != '0) || fetch_valid_o;
  assign protocol_err_o = resp_valid_i && (outstanding_q == '0);

  // Outstanding count goes up on an accepted request and down on a response
  always_comb begin
    case ({req_fire, resp_seen})
      2'b10:   outstanding_n = outstanding_q + CNT_W'(1);
      2'b01:   outstanding_n = outstanding_q - CNT_W'(1);
      default: outstanding_n = outstanding_q;
    endcase
  end

  // Everything in flight at a branch is stale
  // minus the one arriving right now, which is dropped this cycle
  always_comb begin
    flush_n = flush_q;
    if (ctrl_i.branch) begin
      flush_n = outstanding_q - CNT_W'(resp_seen);
    end else if (resp_seen && (flush_q != '0)) begin
      flush_n = flush_q - CNT_W'(1);
    end
  end

  //////////////////////////////////////////////////
  // Instruction count over incoming halfwords
  //////////////////////////////////////////////////

  assign lo_len = (resp_i.rdata[1:0] == `ALBUF_UNCOMP) ? LEN_32 : LEN_16;
  assign hi_len = (resp_i.rdata[17:16] == `ALBUF_UNCOMP) ? LEN_32 : LEN_16;

  always_comb begin
    state_n    = state_q;
    n_incoming = 2'd0;
    if (ctrl_i.branch) begin
      // Odd-halfword target skips the low half of the first word
      state_n = ctrl_i.branch_addr[1] ? UNALIGNED_AFTER_BRANCH : ALIGNED;
    end else if (resp_accept_o) begin
      case (state_q)
        ALIGNED: begin
          if (lo_len == LEN_32) begin
            n_incoming = 2'd1;
          end else if (hi_len == LEN_32) begin
            // Upper half opens an instruction that spills over
            n_incoming = 2'd1;
            state_n    = UNALIGNED_SPLIT;
          end else begin
            n_incoming = 2'd2;
          end
        end
        UNALIGNED_AFTER_BRANCH: begin
          n_incoming = (hi_len == LEN_16) ? 2'd1 : 2'd0;
          state_n    = (hi_len == LEN_16) ? ALIGNED : UNALIGNED_SPLIT;
        end
        default: begin
          // Low half completes the instruction left open
          n_incoming = (hi_len == LEN_16) ? 2'd2 : 2'd1;
          state_n    = (hi_len == LEN_16) ? ALIGNED : UNALIGNED_SPLIT;
        end
      endcase
    end
  end

  // Branch empties the buffer
  assign instr_cnt_n = ctrl_i.branch ? '0 :
                       instr_cnt_adj + (CNT_W+1)'(n_incoming);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_q       <= '0;
      instr_cnt_q   <= '0;
      pop_q         <= 1'b0;
      state_q       <= ALIGNED;
    end else begin
      outstanding_q <= outstanding_n;
      flush_q       <= flush_n;
      instr_cnt_q   <= instr_cnt_n;
      pop_q         <= instr_fire_i;
      state_q       <= state_n;
    end
  end

  // In-flight count stays within the limit and covers every stale response
  a_outstanding_limit: assert property (
    @(posedge clk) disable iff (!rst_n)
    (outstanding_q <= CNT_W'(MAX_OUT)) && (flush_q <= outstanding_q)
  );

endmodule

`default_nettype wire

// ==== design/instr_aligner.sv ====
// Instruction aligner for the alignment buffer
// Builds one 16- or 32-bit instruction from the head word, the word after it
// or the response arriving this cycle, and tracks the halfword address
// The output is combinational, the address moves on after each handshake

`timescale 1ns/1ps
`default_nettype none

`include "albuf_config.svh"

module instr_aligner (
  input  logic                   clk,
  input  logic                   rst_n,
  input  albuf_pkg::albuf_ctrl_t ctrl_i,
  input  albuf_pkg::inst_resp_t  head_i,
  input  logic                   head_valid_i,
  input  albuf_pkg::inst_resp_t  next_i,
  input  logic                   next_valid_i,
  input  logic                   resp_accept_i,
  input  albuf_pkg::inst_resp_t  resp_i,
  input  logic                   instr_ready_i,
  output logic                   instr_valid_o,
  output albuf_pkg::instr_out_t  instr_o,
  output logic                   instr_fire_o,
  output logic                   word_pop_o
);
  import albuf_pkg::*;

  // Halfword address of the instruction on the output
  logic [31:0] addr_q;
  inst_resp_t  cur_word, second_word;
  logic        cur_valid, second_valid;
  logic [15:0] cur_hw;
  instr_len_e  cur_len;
  logic        out_valid;
  logic        word_done;

  //////////////////////////////////////////////////
  // Source selection
  //////////////////////////////////////////////////

  // Head word if buffered, else bypass the response
  assign cur_word  = head_valid_i ? head_i : resp_i;
  assign cur_valid = head_valid_i || resp_accept_i;

  // Second word only exists behind a valid head
  assign second_word  = next_valid_i ? next_i : resp_i;
  assign second_valid = next_valid_i || (head_valid_i && resp_accept_i);

  // First halfword of the instruction
  assign cur_hw  = addr_q[1] ? cur_word.rdata[31:16] : cur_word.rdata[15:0];
  assign cur_len = (cur_hw[1:0] == `ALBUF_UNCOMP) ? LEN_32 : LEN_16;

  always_comb begin
    instr_o.addr  = addr_q;
    instr_o.instr = {16'h0000, cur_hw};
    instr_o.err   = cur_word.err;
    out_valid     = cur_valid;
    // Only an aligned compressed instruction leaves the head in place
    word_done     = addr_q[1] || (cur_len == LEN_32);
    if (cur_len == LEN_32) begin
      if (addr_q[1]) begin
        // Straddles into the following word
        instr_o.instr = {second_word.rdata[15:0], cur_hw};
        instr_o.err   = cur_word.err || second_word.err;
        out_valid     = second_valid;
      end else begin
        instr_o.instr = cur_word.rdata;
      end
    end
  end

  // Nothing goes out in a branch cycle, the stream is being replaced
  assign instr_valid_o = out_valid && !ctrl_i.branch;
  assign instr_fire_o  = instr_valid_o && instr_ready_i;
  assign word_pop_o    = instr_fire_o && word_done;

  //////////////////////////////////////////////////
  // Address register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (ctrl_i.branch) begin
      addr_q <= {ctrl_i.branch_addr[31:1], 1'b0};
    end else if (instr_fire_o) begin
      addr_q <= addr_q + ((cur_len == LEN_32) ? 32'd4 : 32'd2);
    end
  end

  // A held instruction keeps its value, which relies on the word store
  // keeping any bypassed response that was used for it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i && !ctrl_i.branch) |=> $stable(instr_o)
  );

endmodule

`default_nettype wire

// ==== design/word_fifo.sv ====
// Circular store of instruction words for the alignment buffer
// Shows the head word and the one after it so that a straddling
// instruction can be built
// A flush empties it in one cycle

`timescale 1ns/1ps
`default_nettype none

`include "albuf_config.svh"

module word_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  albuf_pkg::inst_resp_t resp_i,
  input  logic                  pop_i,
  output albuf_pkg::inst_resp_t head_o,
  output logic                  head_valid_o,
  output albuf_pkg::inst_resp_t next_o,
  output logic                  next_valid_o
);
  import albuf_pkg::*;

  localparam int DEPTH = `ALBUF_DEPTH;
  localparam int CNT_W = `ALBUF_CNT_W;

  // Word storage qualified by the valid bits
  inst_resp_t       mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q, valid_n;
  logic [CNT_W-1:0] rptr_q, wptr_q, rptr_next;

  // Step a pointer and wrap after the last entry
  function automatic logic [CNT_W-1:0] ptr_inc(input logic [CNT_W-1:0] ptr);
    ptr_inc = (ptr == CNT_W'(DEPTH-1)) ? '0 : ptr + CNT_W'(1);
  endfunction

  assign rptr_next = ptr_inc(rptr_q);

  assign head_o       = mem_q[rptr_q];
  assign head_valid_o = valid_q[rptr_q];
  assign next_o       = mem_q[rptr_next];
  assign next_valid_o = valid_q[rptr_next];

  // Pop after push so a word written and used in one cycle leaves no valid bit
  always_comb begin
    valid_n = valid_q;
    if (push_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (pop_i) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      if (push_i) wptr_q <= ptr_inc(wptr_q);
      if (pop_i)  rptr_q <= rptr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  // Fetch throttling upstream must leave a free slot for every response
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_i |-> !valid_q[wptr_q]
  );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/albuf_pkg.sv
design/fetch_ctrl.sv
design/word_fifo.sv
design/instr_aligner.sv
design/alignment_buffer.sv
tests/tb_clock_gen.sv
tests/tb_alignment_buffer.sv

// ==== tests/tb_alignment_buffer.sv ====
// Testbench for the instruction alignment buffer
// Models the prefetcher and instruction memory, drives random branches and
// back-pressure from a fixed seed, and checks each emitted instruction
// against a halfword walk of the memory image from the last branch target

`timescale 1ns/1ps
`default_nettype none

`include "albuf_config.svh"

module tb_alignment_buffer;
  import albuf_pkg::*;

  // 2000 instructions, 4 cycles of latency each, 8 ns per cycle
  localparam int WATCHDOG_NS = 2000 * 4 * 8;

  logic        clk;
  logic        rst_n;
  albuf_ctrl_t ctrl;
  logic        fetch_valid;
  logic        fetch_ready;
  logic        fetch_branch;
  logic [31:0] fetch_branch_addr;
  logic        resp_valid;
  inst_resp_t  resp;
  logic        instr_valid;
  logic        instr_ready;
  instr_out_t  out_instr;
  logic        busy;
  logic        protocol_err;

  integer      seed = 32'ha0d8_3e47;
  int          cycle_no = 0;
  int          rdy_pct = 100;
  logic        req_on = 1'b0;

  // Prefetcher state with the next word to hand out and the responses in flight
  logic [29:0] next_wa;
  logic [29:0] pend_wa[$];
  int          pend_due[$];
  int          req_cnt = 0;
  int          resp_cnt = 0;

  // Reference model state
  logic        model_live = 1'b0;
  logic [31:0] exp_pc;
  logic        held = 1'b0;
  instr_out_t  held_val;
  int          fired = 0;
  int          err_instrs = 0;

  // Bookkeeping
  int val_errs = 0;
  int flag_errs = 0;
  int stable_errs = 0;
  int limit_errs = 0;
  int proto_errs = 0;
  int port_errs = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int branches = 0;
  int odd_branches = 0;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  alignment_buffer u_alignment_buffer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_i              (ctrl),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_i              (resp),
    .instr_valid_o       (instr_valid),
    .instr_ready_i       (instr_ready),
    .instr_o             (out_instr),
    .busy_o              (busy),
    .protocol_err_o      (protocol_err)
  );

  //////////////////////////////////////////////////
  // Memory image and reference model
  //////////////////////////////////////////////////

  // Hash of the whole word address giving a mix of 16- and 32-bit codes
  function automatic logic [31:0] mem_word(input logic [29:0] wa);
    logic [31:0] x;
    x = {2'b00, wa} * 32'h9e37_79b1;
    x = x ^ (x >> 15);
    x = x * 32'h85eb_ca6b;
    return x ^ (x >> 13);
  endfunction

  // One word address in 32 reports a bus error
  function automatic logic mem_err(input logic [29:0] wa);
    return wa[4:0] == 5'h13;
  endfunction

  function automatic logic [15:0] halfword(input logic [31:0] a);
    logic [31:0] w;
    w = mem_word(a[31:2]);
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic roll_percent(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic int total_errs();
    return val_errs + flag_errs + stable_errs + limit_errs + proto_errs + port_errs;
  endfunction

  // Compare one taken instruction with the next one in the stream
  task automatic check_instr();
    logic [15:0] lo;
    logic [31:0] pc2;
    logic [31:0] exp_word;
    logic        exp_err;
    logic        is32;
    lo       = halfword(exp_pc);
    pc2      = exp_pc + 32'd2;
    is32     = lo[1:0] == `ALBUF_UNCOMP;
    exp_word = is32 ? {halfword(pc2), lo} : {16'h0000, lo};
    // Second halfword may sit in the following word
    exp_err  = mem_err(exp_pc[31:2]) || (is32 && mem_err(pc2[31:2]));
    checks++;
    if (out_instr.addr != exp_pc) begin
      $display("** Error @ %0t: address %h, expected %h", $time, out_instr.addr, exp_pc);
      val_errs++;
    end else if (is32 ? (out_instr.instr != exp_word) : (out_instr.instr[15:0] != lo)) begin
      $display("** Error @ %0t: instruction %h at %h, expected %h",
               $time, out_instr.instr, exp_pc, exp_word);
      val_errs++;
    end
    if (out_instr.err != exp_err) begin
      $display("** Error @ %0t: err %b at %h, expected %b",
               $time, out_instr.err, exp_pc, exp_err);
      flag_errs++;
    end
    if (exp_err) err_instrs++;
    exp_pc = exp_pc + (is32 ? 32'd4 : 32'd2);
  endtask

  //////////////////////////////////////////////////
  // One clock cycle of stimulus and checking
  //////////////////////////////////////////////////

  task automatic step(input logic br, input logic [31:0] tgt, input logic stray);
    logic [29:0] wa;
    logic        got_resp;
    int          inflight;
    @(posedge clk);
    #1;
    cycle_no++;
    ctrl.instr_req   = req_on;
    ctrl.branch      = br;
    ctrl.branch_addr = br ? tgt : 32'h0;
    instr_ready      = roll_percent(rdy_pct);
    fetch_ready      = roll_percent(85);
    resp_valid       = 1'b0;
    resp             = '0;
    got_resp         = 1'b0;
    if (br) begin
      // Prefetcher restarts at the word holding the target
      next_wa    = tgt[31:2];
      exp_pc     = {tgt[31:1], 1'b0};
      model_live = 1'b1;
    end
    if (stray) begin
      resp_valid = 1'b1;
      resp.rdata = 32'h0000_0001;
    end else if (pend_due.size() != 0 && pend_due[0] <= cycle_no) begin
      wa         = pend_wa.pop_front();
      void'(pend_due.pop_front());
      resp_valid = 1'b1;
      resp.rdata = mem_word(wa);
      resp.err   = mem_err(wa);
      resp_cnt++;
      got_resp   = 1'b1;
    end
    // Combinational outputs have settled here well before the next edge
    #2;
    // Requests still owed by the prefetcher, counting the one answered now
    inflight = pend_wa.size() + (got_resp ? 1 : 0);
    if (busy != ((inflight != 0) || fetch_valid)) begin
      $display("** Error @ %0t: busy_o is %b with %0d requests in flight",
               $time, busy, inflight);
      port_errs++;
    end
    if (fetch_branch != br || (br && fetch_branch_addr != {tgt[31:1], 1'b0})) begin
      $display("** Error @ %0t: fetch_branch_o %b to %h, expected %b to %h",
               $time, fetch_branch, fetch_branch_addr, br, {tgt[31:1], 1'b0});
      port_errs++;
    end
    if (fetch_valid && fetch_ready) begin
      pend_wa.push_back(next_wa);
      pend_due.push_back(cycle_no + 1 + int'($unsigned($random(seed)) % 4));
      next_wa = next_wa + 30'd1;
      req_cnt++;
    end
    if (req_cnt - resp_cnt > `ALBUF_MAX_OUTSTANDING) begin
      $display("** Error @ %0t: %0d requests in flight", $time, req_cnt - resp_cnt);
      limit_errs++;
    end
    if (protocol_err != stray) begin
      $display("** Error @ %0t: protocol_err_o is %b, expected %b", $time, protocol_err, stray);
      proto_errs++;
    end
    // A held instruction must come back unchanged unless a branch replaces it
    if (held && !br) begin
      checks++;
      if (!instr_valid || out_instr != held_val) begin
        $display("** Error @ %0t: instruction at %h changed while held", $time, held_val.addr);
        stable_errs++;
      end
    end
    held     = instr_valid && !instr_ready;
    held_val = out_instr;
    if (instr_valid && instr_ready) begin
      fired++;
      if (model_live) begin
        check_instr();
      end else begin
        $display("** Error @ %0t: instruction emitted before any branch", $time);
        val_errs++;
      end
    end
  endtask

  task automatic run_instrs(input int n, input int br_pct);
    int          goal;
    logic        br;
    logic [31:0] tgt;
    goal = fired + n;
    while (fired < goal) begin
      br  = roll_percent(br_pct);
      tgt = $random(seed) & 32'h0000_fffe;
      if (br) begin
        branches++;
        if (tgt[1]) odd_branches++;
      end
      step(br, tgt, 1'b0);
    end
  endtask

  task automatic report(input string name, input int errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("%s: %0d errors, %s", name, errs, (errs == 0) ? "ok" : "FAILED");
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int e0;
    ctrl        = '0;
    fetch_ready = 1'b0;
    resp_valid  = 1'b0;
    resp        = '0;
    instr_ready = 1'b0;
    wait (rst_n === 1'b1);

    // Straight-line fetch from one aligned target
    e0     = total_errs();
    req_on = 1'b1;
    step(1'b1, 32'h0000_1000, 1'b0);
    run_instrs(500, 0);
    report("[1] sequential stream, 500 instructions", total_errs() - e0);

    // Branches mid-stream with about half of them to odd halfwords
    e0 = total_errs();
    run_instrs(500, 4);
    report($sformatf("[2] branches, %0d taken, %0d to odd halfwords",
                     branches, odd_branches), total_errs() - e0);

    // Random stalls on the output side
    e0      = total_errs();
    rdy_pct = 50;
    run_instrs(500, 2);
    report("[3] back-pressure, 500 instructions", total_errs() - e0);

    // These two were checked on every cycle of the runs above
    report($sformatf("[4] error propagation, %0d flagged instructions", err_instrs),
           flag_errs);
    report($sformatf("[5] request limit, %0d requests", req_cnt), limit_errs);

    // Fetch off, drain what is in flight, then a response nobody asked for
    req_on  = 1'b0;
    rdy_pct = 0;
    step(1'b1, 32'h0000_2000, 1'b0);
    while (pend_wa.size() != 0 || busy) begin
      step(1'b0, 32'h0, 1'b0);
    end
    checks++;
    step(1'b0, 32'h0, 1'b1);
    // Branch throws the stray word away
    step(1'b1, 32'h0000_2001, 1'b0);
    report("[6] stray response while idle", proto_errs);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errs());
    if (total_errs() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Clock and reset source for the alignment buffer testbench
// 8 ns clock; reset held low over the first four rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam int HALF_NS    = 4;
  localparam int RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // Release lands 1 ns after an edge, in step with the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
